// File: hw/fp_div_pkg.sv
package fp_div_pkg;

    //////////////////////////////
    // Format widths
    //////////////////////////////

    localparam int FP_WIDTH   = 32;
    localparam int EXP_WIDTH  = 8;
    localparam int FRAC_WIDTH = 23;

    // Fraction plus hidden bit
    localparam int MANT_WIDTH = 24;

    localparam int EXP_BIAS = 127;

    // 24 integer bits then 24 fraction bits
    localparam int QUOT_WIDTH = 48;

    // Leading one here means no exponent change
    localparam int LEAD_REF = 24;

    // Division steps unrolled per pipeline stage
    localparam int STEPS_PER_STAGE = 24;

    //////////////////////////////
    // Float word
    //////////////////////////////

    typedef struct packed {
        logic                  sign;
        logic [EXP_WIDTH-1:0]  exp;
        logic [FRAC_WIDTH-1:0] frac;
    } fp32_t;

    // Raw bits for the reduction checks, fields for the datapath
    typedef union packed {
        logic [FP_WIDTH-1:0] bits;
        fp32_t               fields;
    } fp32_u;

    //////////////////////////////
    // Pipeline stage
    //////////////////////////////

    typedef struct packed {
        logic                  valid;
        logic                  sign;
        logic [EXP_WIDTH-1:0]  exp_biased;
        logic                  exc;
        logic                  zero;
        logic [MANT_WIDTH-1:0] divisor;
        // Partial remainder
        logic [MANT_WIDTH-1:0] rem;
        // Dividend bits not yet shifted in, msb first
        logic [MANT_WIDTH-1:0] dividend_rest;
        // Quotient bits so far, newest at bit 0
        logic [QUOT_WIDTH-1:0] quot;
    } div_stage_t;

endpackage

// File: hw/fp_div_unpack.sv
`timescale 1ns/1ps

module fp_div_unpack (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   in_valid,
    input  fp_div_pkg::fp32_u      a,
    input  fp_div_pkg::fp32_u      b,
    output fp_div_pkg::div_stage_t s_out
);

    import fp_div_pkg::*;

    div_stage_t s_next;
    logic       hidden_a;
    logic       hidden_b;
    logic       exp_a_ones;
    logic       exp_b_ones;
    logic       b_is_zero;
    logic       a_is_zero;

    // Hidden bit only for normal operands
    assign hidden_a = |a.fields.exp;
    assign hidden_b = |b.fields.exp;

    assign exp_a_ones = &a.fields.exp;
    assign exp_b_ones = &b.fields.exp;
    // Magnitude checks ignore the sign bit
    assign a_is_zero  = ~|a.bits[FP_WIDTH-2:0];
    assign b_is_zero  = ~|b.bits[FP_WIDTH-2:0];

    always_comb
    begin
        s_next.valid  = in_valid;
        s_next.sign   = a.fields.sign ^ b.fields.sign;
        // Wraps modulo 256
        s_next.exp_biased = a.fields.exp - b.fields.exp + EXP_WIDTH'(EXP_BIAS);
        s_next.exc    = exp_a_ones | exp_b_ones | b_is_zero;
        s_next.zero   = a_is_zero;
        s_next.divisor       = {hidden_b, b.fields.frac};
        s_next.rem           = '0;
        s_next.dividend_rest = {hidden_a, a.fields.frac};
        s_next.quot          = '0;
    end

    always_ff @(posedge clk)
    begin
        s_out <= s_next;
        if (rst)
        begin
            s_out.valid <= 1'b0;
        end
    end

endmodule

// File: hw/fp_div_steps.sv
`timescale 1ns/1ps

module fp_div_steps #(
    parameter int STEPS = fp_div_pkg::STEPS_PER_STAGE
) (
    input  logic                   clk,
    input  logic                   rst,
    input  fp_div_pkg::div_stage_t s_in,
    output fp_div_pkg::div_stage_t s_out
);

    import fp_div_pkg::*;

    div_stage_t            s_next;
    logic [MANT_WIDTH:0]   shifted;
    logic [MANT_WIDTH+1:0] diff;
    logic                  q;

    //////////////////////////////
    // Restoring division array
    //////////////////////////////

    always_comb
    begin
        s_next  = s_in;
        shifted = '0;
        diff    = '0;
        q       = 1'b0;
        for (int i = 0; i < STEPS; i++)
        begin
            // Next dividend bit, zero once the mantissa is used up
            shifted = {s_next.rem, s_next.dividend_rest[MANT_WIDTH-1]};
            diff    = {1'b0, shifted} - {2'b00, s_next.divisor};
            q       = ~diff[MANT_WIDTH+1];

            // Keep the difference only when it did not go negative
            if (q)
            begin
                s_next.rem = diff[MANT_WIDTH-1:0];
            end
            else
            begin
                s_next.rem = shifted[MANT_WIDTH-1:0];
            end

            s_next.dividend_rest = {s_next.dividend_rest[MANT_WIDTH-2:0], 1'b0};
            s_next.quot          = {s_next.quot[QUOT_WIDTH-2:0], q};
        end
    end

    always_ff @(posedge clk)
    begin
        s_out <= s_next;
        if (rst)
        begin
            s_out.valid <= 1'b0;
        end
    end

    // Remainder stays below divisor across all earlier stages
    a_rem_bound: assert property (@(posedge clk) disable iff (rst)
        (s_out.valid && s_out.divisor != '0) |-> (s_out.rem < s_out.divisor));

endmodule

// File: hw/fp_div_normalize.sv
`timescale 1ns/1ps

module fp_div_normalize (
    input  logic                   clk,
    input  logic                   rst,
    input  fp_div_pkg::div_stage_t s_in,
    output logic                   out_valid,
    output fp_div_pkg::fp32_u      result,
    output logic                   exception
);

    import fp_div_pkg::*;

    logic [EXP_WIDTH-1:0]  lead_pos;
    logic                  found;
    logic [QUOT_WIDTH-1:0] quot_norm;
    logic [EXP_WIDTH-1:0]  exp_adj;
    fp32_u                 result_next;

    //////////////////////////////
    // Leading one encoder
    //////////////////////////////

    // Ascending scan, so the highest set bit wins
    always_comb
    begin
        lead_pos = '0;
        found    = 1'b0;
        for (int i = 0; i < QUOT_WIDTH; i++)
        begin
            if (s_in.quot[i])
            begin
                lead_pos = EXP_WIDTH'(i);
                found    = 1'b1;
            end
        end
    end

    always_comb
    begin
        if (found)
        begin
            quot_norm = s_in.quot << (EXP_WIDTH'(QUOT_WIDTH - 1) - lead_pos);
            exp_adj   = s_in.exp_biased + lead_pos - EXP_WIDTH'(LEAD_REF);
        end
        else
        begin
            quot_norm = s_in.quot;
            exp_adj   = s_in.exp_biased;
        end
    end

    // Truncate, then apply special cases with zero on top
    always_comb
    begin
        result_next.fields.sign = s_in.sign;
        result_next.fields.exp  = exp_adj;
        result_next.fields.frac = quot_norm[QUOT_WIDTH-2 -: FRAC_WIDTH];
        if (s_in.zero)
            result_next.bits = {s_in.sign, {(FP_WIDTH-1){1'b0}}};
        else if (s_in.exc)
            result_next.bits = '1;
    end

    always_ff @(posedge clk)
    begin
        result    <= result_next;
        exception <= s_in.exc & ~s_in.zero;
        if (rst)
            out_valid <= 1'b0;
        else
            out_valid <= s_in.valid;
    end

    // Nothing set above the reported leading one
    a_lead_one: assert property (@(posedge clk) disable iff (rst)
        (s_in.valid && found) |-> ((s_in.quot >> lead_pos) == QUOT_WIDTH'(1)));

endmodule

// File: hw/fp_div.sv
`timescale 1ns/1ps

module fp_div (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    input  fp_div_pkg::fp32_u a,
    input  fp_div_pkg::fp32_u b,
    output logic              out_valid,
    output fp_div_pkg::fp32_u result,
    output logic              exception
);

    import fp_div_pkg::*;

    div_stage_t s_unp;
    div_stage_t s_int;
    div_stage_t s_frac;

    //////////////////////////////
    // Four stage pipeline
    //////////////////////////////

    fp_div_unpack u_unpack (
        .clk      (clk),
        .rst      (rst),
        .in_valid (in_valid),
        .a        (a),
        .b        (b),
        .s_out    (s_unp)
    );

    // Integer quotient bits, consumes the dividend mantissa
    fp_div_steps #(.STEPS(STEPS_PER_STAGE)) u_steps_int (
        .clk   (clk),
        .rst   (rst),
        .s_in  (s_unp),
        .s_out (s_int)
    );

    // Fraction bits, zeros shifted in
    fp_div_steps #(.STEPS(STEPS_PER_STAGE)) u_steps_frac (
        .clk   (clk),
        .rst   (rst),
        .s_in  (s_int),
        .s_out (s_frac)
    );

    fp_div_normalize u_normalize (
        .clk       (clk),
        .rst       (rst),
        .s_in      (s_frac),
        .out_valid (out_valid),
        .result    (result),
        .exception (exception)
    );

endmodule

// File: tb/tb_fp_div.sv
`timescale 1ns/1ps

module tb_fp_div;

    import fp_div_pkg::*;

    localparam int NUM_VECTORS    = 32;
    localparam int WORDS_PER_VEC  = 4;
    localparam int RESET_CYCLES   = 3;
    localparam int LATENCY        = 4;
    localparam int TIMEOUT_CYCLES = NUM_VECTORS + RESET_CYCLES + LATENCY + 20;

    typedef struct packed {
        logic [FP_WIDTH-1:0] result;
        logic                exc;
        int                  idx;
        int                  issue;
    } expect_t;

    logic  clk;
    logic  rst;
    logic  in_valid;
    fp32_u a;
    fp32_u b;
    logic  out_valid;
    fp32_u result;
    logic  exception;

    logic [FP_WIDTH-1:0] golden [0:NUM_VECTORS*WORDS_PER_VEC-1];
    expect_t             exp_q[$];
    int                  cycle = 0;
    int                  errors = 0;
    int                  checks = 0;

    fp_div UUT (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .result    (result),
        .exception (exception)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
    end

    //////////////////////////////
    // Result checking
    //////////////////////////////

    task check_output;
        expect_t e;
    begin
        if (exp_q.size() == 0)
        begin
            $display("Output valid at time %0t with no vector outstanding", $time);
            errors++;
        end
        else
        begin
            e = exp_q.pop_front();
            checks++;
            if (result.bits !== e.result)
            begin
                $display("[ERROR] t=%0t vector %0d result %08h, expected %08h",
                         $time, e.idx, result.bits, e.result);
                errors++;
            end
            if (exception !== e.exc)
            begin
                $display("[ERROR] t=%0t vector %0d exception %0b, expected %0b",
                         $time, e.idx, exception, e.exc);
                errors++;
            end
            if (cycle - e.issue != LATENCY)
            begin
                $display("[ERROR] t=%0t vector %0d latency %0d, expected %0d",
                         $time, e.idx, cycle - e.issue, LATENCY);
                errors++;
            end
        end
    end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk)
    begin
        if (!rst && out_valid)
            check_output();
    end

    task finish_run;
    begin
        if (exp_q.size() != 0)
        begin
            $display("%0d expected results never came out", exp_q.size());
            errors++;
        end
        $display("Checked %0d results, %0d errors", checks, errors);
        if (errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end
    endtask

    initial
    begin
        wait (cycle >= TIMEOUT_CYCLES);
        $display("Timeout at cycle %0d, the results did not arrive", cycle);
        errors++;
        finish_run();
    end

    //////////////////////////////
    // Stimulus
    //////////////////////////////

    initial
    begin
        expect_t e;
        rst      = 1'b1;
        in_valid = 1'b0;
        a.bits   = '0;
        b.bits   = '0;
        $readmemh("tb/fp_div_golden.txt", golden);

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // Back to back, one vector per cycle
        for (int i = 0; i < NUM_VECTORS; i++)
        begin
            a.bits   = golden[i*WORDS_PER_VEC];
            b.bits   = golden[i*WORDS_PER_VEC+1];
            in_valid = 1'b1;
            e.result = golden[i*WORDS_PER_VEC+2];
            e.exc    = golden[i*WORDS_PER_VEC+3][0];
            e.idx    = i;
            e.issue  = cycle;
            exp_q.push_back(e);
            @(negedge clk);
        end
        in_valid = 1'b0;
        a.bits   = '0;
        b.bits   = '0;

        while (exp_q.size() != 0)
            @(negedge clk);
        repeat (2) @(negedge clk);
        finish_run();
    end

endmodule

// File: tb/fp_div_golden.txt
// Columns: a  b  expected_result  expected_exception (hex words)
// Results are truncated, exponent wraps modulo 256
// Normal quotients
40C00000 40000000 40400000 0
3F800000 40400000 3EAAAAAA 0
3F800000 3F800000 3F800000 0
41200000 40800000 40200000 0
3F800000 40E00000 3E124924 0
40400000 3FC00000 40000000 0
42C80000 41200000 41200000 0
40000000 40400000 3F2AAAAA 0
3FC00000 3FA00000 3F999999 0
// Sign combinations
C0C00000 40000000 C0400000 0
40C00000 C0000000 C0400000 0
C0C00000 C0000000 40400000 0
BF800000 40400000 BEAAAAAA 0
3F800000 C0E00000 BE124924 0
// Exceptions: all-ones exponent or zero divisor
7F800000 3F800000 FFFFFFFF 1
3F800000 7FC00000 FFFFFFFF 1
3F800000 00000000 FFFFFFFF 1
C0000000 80000000 FFFFFFFF 1
FF800000 40000000 FFFFFFFF 1
// Zero dividend wins over the exception
00000000 40000000 00000000 0
80000000 40000000 80000000 0
00000000 80000000 80000000 0
00000000 7F800000 00000000 0
80000000 C0400000 00000000 0
// Subnormal operands
00400000 3F800000 7F800000 0
00000001 3F800000 74800000 0
00000003 3F800000 75400000 0
3F800000 00000001 0A800000 0
00200000 00400000 3F000000 0
80000003 3F800000 F5400000 0
// Exponent wrap
7F000000 00800000 3E000000 0
00800000 7F000000 41000000 0

// File: flist.f
hw/fp_div_pkg.sv
hw/fp_div_unpack.sv
hw/fp_div_steps.sv
hw/fp_div_normalize.sv
hw/fp_div.sv
tb/tb_fp_div.sv

// File: run_sim.sh
#!/usr/bin/env bash

# Build and run the floating-point divider testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_fp_div -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_fp_div)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -qx "TB PASSED" <<< "$sim_out"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
